// ==== hdl/nf_params.svh ====
// ==============================
// widths, address map and sizes
// ==============================
`ifndef NF_PARAMS_SVH
`define NF_PARAMS_SVH

`define NF_DATA_W     32    // data and address width
`define NF_GPIO_W     8     // gpio pin count
`define NF_PWM_W      8     // pwm counter and duty width
`define NF_RAM_DEPTH  64    // data ram words
`define NF_ROM_DEPTH  16    // program rom words
`define NF_DIV_W      26    // strobe divider width
`define NF_REG_N      8     // cpu registers, r0 hardwired zero

`define NF_SEL_HI     13    // slave select field
`define NF_SEL_LO     12

`define NF_GPIO_IN    0     // gpio register offsets
`define NF_GPIO_OUT   4
`define NF_GPIO_DIR   8

`endif

// ==== hdl/nf_pkg.sv ====
// ==============================
// opcodes, instruction fields
// slave regions, offset helper
// ==============================
`include "nf_params.svh"

package nf_pkg;

    typedef enum logic [3:0] {
        OP_NOP = 4'd0,
        OP_LI  = 4'd1,                      // rd = imm
        OP_ADD = 4'd2,                      // rd = rs1 + rs2
        OP_LW  = 4'd3,                      // rd = mem[rs1 + imm]
        OP_SW  = 4'd4,                      // mem[rs1 + imm] = rs2
        OP_BNE = 4'd5,                      // pc += imm if rs1 != rs2
        OP_JMP = 4'd6                       // pc = imm
    } nf_op_e;

    typedef logic [2:0] nf_reg_idx_t;       // register number

    typedef struct packed {
        nf_op_e      op;
        nf_reg_idx_t rd;
        nf_reg_idx_t rs1;
        nf_reg_idx_t rs2;
        logic [2:0]  pad;                   // spare, kept zero
        logic [15:0] imm;
    } nf_instr_t;

    typedef enum logic [1:0] {
        SL_RAM  = 2'd0,                     // 0x0000
        SL_GPIO = 2'd1,                     // 0x1000
        SL_PWM  = 2'd2,                     // 0x2000
        SL_NONE = 2'd3                      // 0x3000, reads zero
    } nf_slave_e;

    // byte offset inside a slave region
    function automatic logic [`NF_SEL_LO-1:0] nf_off(input logic [`NF_DATA_W-1:0] a);
        return a[`NF_SEL_LO-1:0];
    endfunction

endpackage : nf_pkg

// ==== hdl/nf_bus_if.sv ====
// ==============================
// single cycle data bus
// ==============================
`timescale 1ns/1ps
`include "nf_params.svh"

interface nf_bus_if;

    logic [`NF_DATA_W-1:0] addr;            // byte address
    logic                  we;              // write strobe, one cycle
    logic [`NF_DATA_W-1:0] wd;              // write data
    logic [`NF_DATA_W-1:0] rd;              // read data, combinational

    modport master (
        output addr, we, wd,
        input  rd
    );

    modport slave (
        input  addr, we, wd,
        output rd
    );

endinterface : nf_bus_if

// ==== hdl/nf_cpu.sv ====
// ==============================
// cpu core with strobe divider
// regfile, decode and debug scan
// ==============================
`timescale 1ns/1ps
`include "nf_params.svh"

module nf_cpu (
    input  logic                             clk,
    input  logic                             rst_n,
    input  logic [`NF_DIV_W-1:0]             div,         // strobe period minus one
    output logic [$clog2(`NF_ROM_DEPTH)-1:0] instr_addr,  // word index
    input  nf_pkg::nf_instr_t                instr,
    nf_bus_if.master                         bus,
    input  nf_pkg::nf_reg_idx_t              reg_addr,    // scan select
    output logic [`NF_DATA_W-1:0]            reg_data     // scan data
);

    import nf_pkg::*;

    localparam int PC_W = $clog2(`NF_ROM_DEPTH);
    localparam int DW   = `NF_DATA_W;

    logic [`NF_DIV_W-1:0] div_cnt;                        // strobe divider
    logic                 cpu_en;                         // execute strobe
    logic [PC_W-1:0]      pc;
    logic [PC_W-1:0]      pc_next;
    logic [DW-1:0]        regs [`NF_REG_N];
    logic [DW-1:0]        rs1_val;
    logic [DW-1:0]        rs2_val;
    logic [DW-1:0]        imm_sx;                         // sign extended imm
    logic [DW-1:0]        wb_data;
    logic                 wb_en;

    // one pulse every div+1 clocks
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            div_cnt <= '0;
            cpu_en  <= 1'b0;
        end else if (div_cnt >= div) begin            // >= so a smaller div never stalls
            div_cnt <= '0;
            cpu_en  <= 1'b1;
        end else begin
            div_cnt <= div_cnt + 1'b1;
            cpu_en  <= 1'b0;
        end
    end

    assign instr_addr = pc;

    // operand fetch, r0 reads zero
    assign rs1_val = (instr.rs1 == '0) ? '0 : regs[instr.rs1];
    assign rs2_val = (instr.rs2 == '0) ? '0 : regs[instr.rs2];
    assign imm_sx  = {{(DW-16){instr.imm[15]}}, instr.imm};

    // data bus, address shared by LW and SW
    assign bus.addr = rs1_val + imm_sx;
    assign bus.wd   = rs2_val;
    assign bus.we   = cpu_en && (instr.op == OP_SW);   // store only on strobe

    // decode and execute
    always_comb begin
        wb_en   = 1'b0;
        wb_data = '0;
        pc_next = pc + 1'b1;                          // fall through
        case (instr.op)
            OP_LI: begin
                wb_en   = 1'b1;
                wb_data = DW'(instr.imm);             // zero extended
            end
            OP_ADD: begin
                wb_en   = 1'b1;
                wb_data = rs1_val + rs2_val;
            end
            OP_LW: begin
                wb_en   = 1'b1;
                wb_data = bus.rd;                     // async slave read
            end
            OP_BNE: begin
                if (rs1_val != rs2_val)
                    pc_next = pc + instr.imm[PC_W-1:0];  // pc relative
            end
            OP_JMP: begin
                pc_next = instr.imm[PC_W-1:0];       // absolute word index
            end
            default: ;                                // NOP, SW is the bus strobe
        endcase
    end

    // state update at the end of the strobe cycle
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pc <= '0;
            for (int i = 0; i < `NF_REG_N; i++)
                regs[i] <= '0;
        end else if (cpu_en) begin
            pc <= pc_next;
            if (wb_en && (instr.rd != '0))            // r0 never written
                regs[instr.rd] <= wb_data;
        end
    end

    // debug scan port
    assign reg_data = (reg_addr == '0) ? '0 : regs[reg_addr];

endmodule : nf_cpu

// ==== hdl/nf_instr_mem.sv ====
// ==============================
// fixed program rom
// ==============================
`timescale 1ns/1ps
`include "nf_params.svh"

module nf_instr_mem (
    input  logic [$clog2(`NF_ROM_DEPTH)-1:0] addr,     // word index
    output logic [`NF_DATA_W-1:0]            instr
);

    import nf_pkg::*;

    // pack one instruction word
    function automatic nf_instr_t mk(input nf_op_e op, input nf_reg_idx_t rd,
                                     input nf_reg_idx_t rs1, input nf_reg_idx_t rs2,
                                     input logic [15:0] imm);
        nf_instr_t i;
        i.op  = op;
        i.rd  = rd;
        i.rs1 = rs1;
        i.rs2 = rs2;
        i.pad = '0;
        i.imm = imm;
        return i;
    endfunction

    always_comb begin
        case (addr)
            4'd0:    instr = mk(OP_LI,  3'd4, 3'd0, 3'd0, 16'h1000);  // r4 = gpio base
            4'd1:    instr = mk(OP_LI,  3'd5, 3'd0, 3'd0, 16'h2000);  // r5 = pwm base
            4'd2:    instr = mk(OP_LI,  3'd2, 3'd0, 3'd0, 16'h00FF);  // r2 = all ones byte
            4'd3:    instr = mk(OP_SW,  3'd0, 3'd4, 3'd2, 16'h0008);  // gpd = 0xff
            4'd4:    instr = mk(OP_LW,  3'd1, 3'd4, 3'd0, 16'h0000);  // loop, r1 = gpi
            4'd5:    instr = mk(OP_SW,  3'd0, 3'd4, 3'd1, 16'h0004);  // gpo = r1
            4'd6:    instr = mk(OP_ADD, 3'd3, 3'd1, 3'd2, 16'h0000);  // r3 = gpi + 255
            4'd7:    instr = mk(OP_SW,  3'd0, 3'd0, 3'd3, 16'h0010);  // ram[4] = r3
            4'd8:    instr = mk(OP_LW,  3'd6, 3'd0, 3'd0, 16'h0010);  // r6 = ram[4]
            4'd9:    instr = mk(OP_SW,  3'd0, 3'd5, 3'd6, 16'h0000);  // duty = r6
            4'd10:   instr = mk(OP_JMP, 3'd0, 3'd0, 3'd0, 16'h0004);  // back to loop
            default: instr = mk(OP_NOP, 3'd0, 3'd0, 3'd0, 16'h0000);
        endcase
    end

endmodule : nf_instr_mem

// ==== hdl/nf_router.sv ====
// ==============================
// address decode and read mux
// ==============================
`timescale 1ns/1ps
`include "nf_params.svh"

module nf_router (
    nf_bus_if.slave  m,                       // from cpu
    nf_bus_if.master s_ram,
    nf_bus_if.master s_gpio,
    nf_bus_if.master s_pwm
);

    import nf_pkg::*;

    nf_slave_e sel;                           // selected region

    assign sel = nf_slave_e'(m.addr[`NF_SEL_HI:`NF_SEL_LO]);

    // address and data go everywhere
    assign s_ram.addr  = m.addr;
    assign s_ram.wd    = m.wd;
    assign s_gpio.addr = m.addr;
    assign s_gpio.wd   = m.wd;
    assign s_pwm.addr  = m.addr;
    assign s_pwm.wd    = m.wd;

    // write strobe only to the selected slave
    assign s_ram.we  = m.we && (sel == SL_RAM);
    assign s_gpio.we = m.we && (sel == SL_GPIO);
    assign s_pwm.we  = m.we && (sel == SL_PWM);

    // read data back to the master
    always_comb begin
        case (sel)
            SL_RAM:  m.rd = s_ram.rd;
            SL_GPIO: m.rd = s_gpio.rd;
            SL_PWM:  m.rd = s_pwm.rd;
            default: m.rd = '0;               // unmapped reads zero
        endcase
    end

endmodule : nf_router

// ==== hdl/nf_ram.sv ====
// ==============================
// data ram, async read
// ==============================
`timescale 1ns/1ps
`include "nf_params.svh"

module nf_ram (
    input logic     clk,
    nf_bus_if.slave bus
);

    import nf_pkg::*;

    localparam int AW = $clog2(`NF_RAM_DEPTH);

    logic [`NF_DATA_W-1:0] mem [`NF_RAM_DEPTH];
    logic [`NF_SEL_LO-1:0] off;               // byte offset in region
    logic [AW-1:0]         idx;               // word index, aliases past depth

    assign off = nf_off(bus.addr);
    assign idx = off[AW+1:2];

    always_ff @(posedge clk) begin
        if (bus.we)
            mem[idx] <= bus.wd;
    end

    assign bus.rd = mem[idx];

endmodule : nf_ram

// ==== hdl/nf_gpio.sv ====
// ==============================
// gpio with input synchronizer
// ==============================
`timescale 1ns/1ps
`include "nf_params.svh"

module nf_gpio (
    input  logic                  clk,
    input  logic                  rst_n,
    nf_bus_if.slave               bus,
    input  logic [`NF_GPIO_W-1:0] gpi,    // async pins
    output logic [`NF_GPIO_W-1:0] gpo,
    output logic [`NF_GPIO_W-1:0] gpd     // 1 = output
);

    import nf_pkg::*;

    localparam int DW = `NF_DATA_W;

    logic [`NF_GPIO_W-1:0] gpi_s1;        // first sync stage
    logic [`NF_GPIO_W-1:0] gpi_s2;        // safe to read
    logic [`NF_SEL_LO-1:0] off;

    assign off = nf_off(bus.addr);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            gpi_s1 <= '0;
            gpi_s2 <= '0;
        end else begin
            gpi_s1 <= gpi;
            gpi_s2 <= gpi_s1;
        end
    end

    // output and direction registers
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            gpo <= '0;
            gpd <= '0;
        end else if (bus.we) begin
            if (off == `NF_GPIO_OUT)
                gpo <= bus.wd[`NF_GPIO_W-1:0];
            if (off == `NF_GPIO_DIR)
                gpd <= bus.wd[`NF_GPIO_W-1:0];
        end
    end

    always_comb begin
        case (off)
            `NF_GPIO_IN:  bus.rd = DW'(gpi_s2);
            `NF_GPIO_OUT: bus.rd = DW'(gpo);
            `NF_GPIO_DIR: bus.rd = DW'(gpd);
            default:      bus.rd = '0;
        endcase
    end

endmodule : nf_gpio

// ==== hdl/nf_pwm.sv ====
// ==============================
// pwm with duty register
// ==============================
`timescale 1ns/1ps
`include "nf_params.svh"

module nf_pwm (
    input  logic    clk,
    input  logic    rst_n,
    nf_bus_if.slave bus,
    output logic    pwm
);

    import nf_pkg::*;

    localparam int DW = `NF_DATA_W;

    logic [`NF_PWM_W-1:0]  duty;              // high cycles per period
    logic [`NF_PWM_W-1:0]  cnt;               // free running, wraps
    logic [`NF_SEL_LO-1:0] off;

    assign off = nf_off(bus.addr);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n)
            duty <= '0;
        else if (bus.we && (off == '0))
            duty <= bus.wd[`NF_PWM_W-1:0];
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cnt <= '0;
            pwm <= 1'b0;
        end else begin
            cnt <= cnt + 1'b1;
            pwm <= (cnt < duty);              // registered compare
        end
    end

    assign bus.rd = (off == '0) ? DW'(duty) : '0;

endmodule : nf_pwm

// ==== hdl/nf_top.sv ====
// ==============================
// subsystem top, cpu and slaves
// ==============================
`timescale 1ns/1ps
`include "nf_params.svh"

module nf_top (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic [`NF_DIV_W-1:0]  div,        // cpu strobe divider
    input  logic [`NF_GPIO_W-1:0] gpi,
    output logic [`NF_GPIO_W-1:0] gpo,
    output logic [`NF_GPIO_W-1:0] gpd,
    output logic                  pwm,
    input  nf_pkg::nf_reg_idx_t   reg_addr,   // debug scan
    output logic [`NF_DATA_W-1:0] reg_data
);

    import nf_pkg::*;

    logic [$clog2(`NF_ROM_DEPTH)-1:0] instr_addr;
    nf_instr_t                        instr;

    nf_bus_if cpu_bus ();                     // cpu to router
    nf_bus_if ram_bus ();
    nf_bus_if gpio_bus ();
    nf_bus_if pwm_bus ();

    nf_cpu nf_cpu_0 (
        .clk        ( clk        ),
        .rst_n      ( rst_n      ),
        .div        ( div        ),
        .instr_addr ( instr_addr ),
        .instr      ( instr      ),
        .bus        ( cpu_bus    ),
        .reg_addr   ( reg_addr   ),
        .reg_data   ( reg_data   )
    );

    nf_instr_mem nf_instr_mem_0 (
        .addr       ( instr_addr ),
        .instr      ( instr      )           // struct view of rom word
    );

    nf_router nf_router_0 (
        .m          ( cpu_bus    ),
        .s_ram      ( ram_bus    ),
        .s_gpio     ( gpio_bus   ),
        .s_pwm      ( pwm_bus    )
    );

    nf_ram nf_ram_0 (
        .clk        ( clk        ),
        .bus        ( ram_bus    )
    );

    nf_gpio nf_gpio_0 (
        .clk        ( clk        ),
        .rst_n      ( rst_n      ),
        .bus        ( gpio_bus   ),
        .gpi        ( gpi        ),
        .gpo        ( gpo        ),
        .gpd        ( gpd        )
    );

    nf_pwm nf_pwm_0 (
        .clk        ( clk        ),
        .rst_n      ( rst_n      ),
        .bus        ( pwm_bus    ),
        .pwm        ( pwm        )
    );

endmodule : nf_top

// ==== verification/nf_top_sva.sv ====
// ==============================
// bound checks for reset values
// and bus write timing
// ==============================
`timescale 1ns/1ps
`include "nf_params.svh"

module nf_top_sva (
    input logic                  clk,
    input logic                  rst_n,
    input logic [`NF_GPIO_W-1:0] gpo,
    input logic [`NF_GPIO_W-1:0] gpd,
    input logic                  pwm,
    input logic                  bus_we,     // cpu side write strobe
    input logic                  cpu_en      // execute strobe
);

    int fail_cnt = 0;                        // failed assertion count

    // outputs held at zero while in reset
    a_reset_vals: assert property (@(posedge clk)
        !rst_n |-> (gpo == '0) && (gpd == '0) && !pwm)
        else begin
            $error("outputs not zero during reset");
            fail_cnt++;
        end

    // first clock after release still shows reset values
    a_release_vals: assert property (@(posedge clk)
        $rose(rst_n) |-> (gpo == '0) && (gpd == '0) && !pwm)
        else begin
            $error("outputs not zero at reset release");
            fail_cnt++;
        end

    a_quiet_in_reset: assert property (@(posedge clk)
        !rst_n |-> !cpu_en && !bus_we)
        else begin
            $error("strobe or bus write during reset");
            fail_cnt++;
        end

    // stores only inside a strobe cycle and one cycle long
    a_we_on_strobe: assert property (@(posedge clk) disable iff (!rst_n)
        bus_we |-> cpu_en ##1 !bus_we)
        else begin
            $error("bus write outside a strobe cycle or longer than one cycle");
            fail_cnt++;
        end

endmodule : nf_top_sva

bind nf_top nf_top_sva i_sva (
    .clk    ( clk             ),
    .rst_n  ( rst_n           ),
    .gpo    ( gpo             ),
    .gpd    ( gpd             ),
    .pwm    ( pwm             ),
    .bus_we ( cpu_bus.we      ),
    .cpu_en ( nf_cpu_0.cpu_en )
);

// ==== verification/nf_top_tb.sv ====
// ==============================
// testbench for nf_top, row table
// of div and gpi with expectations
// ==============================
`timescale 1ns/1ps
`include "nf_params.svh"

module nf_top_tb;

    localparam int N_FIXED = 12;             // 3 div values x 4 gpi values
    localparam int N_RAND  = 4;
    localparam int N_ROWS  = N_FIXED + N_RAND;
    localparam int PWM_WIN = 256;            // one full counter period

    typedef struct packed {
        logic [`NF_DIV_W-1:0]  div;
        logic [`NF_GPIO_W-1:0] gpi;
        logic [31:0]           gpo;
        logic [31:0]           gpd;
        logic [31:0]           r3;
        logic [31:0]           r6;
        logic [31:0]           pwm_hi;       // high cycles per window
    } row_t;

    logic                  clk;
    logic                  rst_n;
    logic [`NF_DIV_W-1:0]  div;
    logic [`NF_GPIO_W-1:0] gpi;
    logic [`NF_GPIO_W-1:0] gpo;
    logic [`NF_GPIO_W-1:0] gpd;
    logic                  pwm;
    logic [2:0]            reg_addr;
    logic [`NF_DATA_W-1:0] reg_data;

    row_t rows [N_ROWS];
    int   n_checks;
    int   n_errors;

    nf_top i_dut (
        .clk      ( clk      ),
        .rst_n    ( rst_n    ),
        .div      ( div      ),
        .gpi      ( gpi      ),
        .gpo      ( gpo      ),
        .gpd      ( gpd      ),
        .pwm      ( pwm      ),
        .reg_addr ( reg_addr ),
        .reg_data ( reg_data )
    );

    always #2 clk = ~clk;                    // 4 ns period

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    // expected results of one pass of the program loop
    function automatic row_t make_row(input logic [`NF_DIV_W-1:0] d,
                                      input logic [`NF_GPIO_W-1:0] g);
        row_t        r;
        logic [31:0] sum;
        sum      = 32'(g) + 32'd255;
        r.div    = d;
        r.gpi    = g;
        r.gpo    = 32'(g);
        r.gpd    = 32'h0000_00ff;            // all pins driven
        r.r3     = sum;
        r.r6     = sum;                      // ram round trip
        r.pwm_hi = 32'(sum[7:0]);
        return r;
    endfunction

    task automatic build_rows();
        logic [`NF_GPIO_W-1:0] gpi_set [4];
        logic [`NF_DIV_W-1:0]  div_set [3];
        logic [31:0]           seed;
        int                    k;
        gpi_set = '{8'h00, 8'h01, 8'h80, 8'hff};
        div_set = '{`NF_DIV_W'(0), `NF_DIV_W'(1), `NF_DIV_W'(3)};
        k = 0;
        for (int d = 0; d < 3; d++) begin
            for (int g = 0; g < 4; g++) begin
                rows[k] = make_row(div_set[d], gpi_set[g]);
                k++;
            end
        end
        seed = 32'h2731;
        for (int i = 0; i < N_RAND; i++) begin
            seed    = lcg_next(seed);
            rows[k] = make_row(`NF_DIV_W'(seed[19:16]), seed[15:8]);  // div up to 15
            k++;
        end
    endtask

    task automatic check_value(input string what, input logic [31:0] got,
                               input logic [31:0] exp);
        n_checks++;
        if (got !== exp) begin
            n_errors++;
            $display("[FAIL] %0t ns: %s got %h expected %h", $time, what, got, exp);
        end
    endtask

    // scan port read sampled mid cycle
    task automatic read_reg(input logic [2:0] idx, output logic [31:0] val);
        @(negedge clk);
        reg_addr = idx;
        #1;
        val = reg_data;
    endtask

    task automatic wait_gpo(input logic [`NF_GPIO_W-1:0] want, input int limit,
                            output logic ok);
        int cycles;
        ok     = 1'b0;
        cycles = 0;
        while (!ok && cycles < limit) begin
            @(negedge clk);
            if (gpo == want)
                ok = 1'b1;
            cycles++;
        end
        if (!ok) begin
            n_errors++;
            $display("timeout: gpo did not reach %h within %0d cycles", want, limit);
        end
    endtask

    task automatic count_pwm(input int window, output int hi);
        hi = 0;
        for (int c = 0; c < window; c++) begin
            @(negedge clk);
            if (pwm)
                hi++;
        end
    endtask

    initial begin
        row_t        r;
        logic [31:0] val;
        logic        ok;
        int          hi;
        int          limit;
        int          sva_errs;
        clk      = 1'b0;
        rst_n    = 1'b0;
        div      = '0;
        gpi      = '0;
        reg_addr = '0;
        n_checks = 0;
        n_errors = 0;
        build_rows();
        repeat (5) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        check_value("gpo after reset", 32'(gpo), 32'd0);
        check_value("gpd after reset", 32'(gpd), 32'd0);
        check_value("pwm after reset", 32'(pwm), 32'd0);
        for (int i = 0; i < N_ROWS; i++) begin
            r = rows[i];
            @(negedge clk);
            div   = r.div;
            gpi   = r.gpi;
            limit = 20 * (int'(r.div) + 1) + 10;     // loop is 7 strobes plus sync
            wait_gpo(r.gpi, limit, ok);
            repeat (14 * (int'(r.div) + 1) + 4) @(negedge clk);  // two full loop passes
            check_value($sformatf("row %0d gpo", i), 32'(gpo), r.gpo);
            check_value($sformatf("row %0d gpd", i), 32'(gpd), r.gpd);
            read_reg(3'd3, val);
            check_value($sformatf("row %0d r3", i), val, r.r3);
            read_reg(3'd6, val);
            check_value($sformatf("row %0d r6", i), val, r.r6);
            read_reg(3'd0, val);
            check_value($sformatf("row %0d r0", i), val, 32'd0);
            count_pwm(PWM_WIN, hi);
            check_value($sformatf("row %0d pwm high", i), 32'(hi), r.pwm_hi);
        end
        sva_errs = i_dut.i_sva.fail_cnt;
        n_errors += sva_errs;
        $display("checks %0d, errors %0d, assertion failures %0d",
                 n_checks, n_errors, sva_errs);
        if (n_errors == 0)
            $display("All tests passed");
        else
            $display("Some tests failed");
        $finish;
    end

endmodule : nf_top_tb

// ==== all.f ====
+incdir+hdl
hdl/nf_pkg.sv
hdl/nf_bus_if.sv
hdl/nf_cpu.sv
hdl/nf_instr_mem.sv
hdl/nf_router.sv
hdl/nf_ram.sv
hdl/nf_gpio.sv
hdl/nf_pwm.sv
hdl/nf_top.sv
verification/nf_top_sva.sv
verification/nf_top_tb.sv

// ==== Makefile ====
# Verilator build and run for the nf_top testbench

VERILATOR ?= verilator
TOP       ?= nf_top_tb
FILELIST  ?= all.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert
RUN_ARGS  ?= +verilator+error+limit+100
FAIL_MSG  := Some tests failed
PASS_MSG  := All tests passed

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	./$(OBJ_DIR)/V$(TOP) $(RUN_ARGS) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "simulation failed"; exit 1; fi
	@if ! grep -q "$(PASS_MSG)" $(LOG); then echo "simulation ended early"; exit 1; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
